//--- Makefile
# Verilator build and run for the pooling engine testbench

VERILATOR ?= verilator
TOP       ?= tb_pool_engine
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
source/pool_pkg.sv
source/atom_deserializer.sv
source/pool_lanes.sv
source/result_writer.sv
source/pool_ctrl.sv
source/pool_engine.sv
test/tb_dma_model.sv
test/tb_pool_engine.sv

//--- source/atom_deserializer.sv
`timescale 1ns/10ps

module atom_deserializer (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_rd_we,
	input  pool_pkg::word_t i_rd_data,
	output logic            o_atom_valid,
	output pool_pkg::atom_t o_atom_data
);
	import pool_pkg::*;

	logic [BURST_SHIFT-1:0] word_cnt;  // Position inside the burst

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= i_rd_we && (&word_cnt);  // Eighth word completes the atom
			if (i_rd_we) word_cnt <= word_cnt + 1'b1;
		end
	end

	// New words enter at the top, word 0 lands in lane 0 after a full burst
	always_ff @(posedge clk) begin
		if (i_rd_we) begin
			o_atom_data <= {i_rd_data, o_atom_data[BURST_LEN*WORD_W-1:WORD_W]};
		end
	end

endmodule

//--- source/pool_ctrl.sv
`timescale 1ns/10ps

module pool_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,
	input  pool_pkg::pool_op_t i_op,
	input  logic [1:0]         i_win_shift,
	input  pool_pkg::count_t   i_stride,
	input  pool_pkg::count_t   i_windows,
	input  pool_pkg::addr_t    i_data_addr,
	input  logic               i_rd_we,
	input  logic               i_atom_valid,
	input  logic               i_wr_busy,
	input  logic               i_wr_done,
	output logic               o_ready,
	output logic               o_rd_en,
	output pool_pkg::addr_t    o_rd_addr,
	output pool_pkg::pool_op_t o_op,
	output logic [1:0]         o_win_shift,
	output logic               o_atom_first,
	output logic               o_atom_last
);
	import pool_pkg::*;

	ctrl_state_t            state;
	ctrl_state_t            state_nxt;
	count_t                 stride_q;
	count_t                 windows_q;
	count_t                 last_atom;   // Index of the final atom in a window
	count_t                 rd_win;      // Windows fully read
	count_t                 rd_atom;     // Atom being read within the window
	count_t                 lane_atom;   // Atom arriving at the lanes
	count_t                 done_cnt;    // Windows fully written
	logic [BURST_SHIFT-1:0] rd_word;
	addr_t                  base_addr;   // First word of the window being read
	addr_t                  win_step;
	logic                   accept;
	logic                   win_end;
	logic                   reads_left;
	logic                   stall;
	logic                   res_pend;    // Window result still between reader and writer
	logic                   job_end;

	assign accept     = (state == ST_IDLE) && i_start && ((i_op == OP_MAX) || (i_op == OP_AVG));
	assign last_atom  = (count_t'(1) << o_win_shift) - count_t'(1);  // 2^shift atoms
	assign win_step   = addr_t'(stride_q) << BURST_SHIFT;             // Stride in words
	assign win_end    = i_rd_we && (&rd_word) && (rd_atom == last_atom);
	assign reads_left = (rd_win != windows_q);
	assign job_end    = i_wr_done && !reads_left && ((done_cnt + count_t'(1)) == windows_q);

	// Hold off the last atom while an earlier result still occupies the writer path
	assign stall   = (rd_word == '0) && (rd_atom == last_atom) && (i_wr_busy || res_pend);
	assign o_rd_en = (state == ST_READ) && reads_left && !stall;

	assign o_atom_first = (lane_atom == '0);
	assign o_atom_last  = (lane_atom == last_atom);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (accept) state_nxt = ST_READ;
			end
			ST_READ: begin
				if (job_end) state_nxt = ST_DONE;  // Final window written
			end
			default: state_nxt = ST_IDLE;         // ST_DONE lasts one cycle
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= ST_IDLE;
			o_ready     <= 1'b0;
			o_op        <= OP_MAX;
			o_win_shift <= '0;
			stride_q    <= '0;
			windows_q   <= '0;
			rd_win      <= '0;
			rd_atom     <= '0;
			rd_word     <= '0;
			lane_atom   <= '0;
			done_cnt    <= '0;
			res_pend    <= 1'b0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				o_ready     <= 1'b0;
				o_op        <= i_op;
				o_win_shift <= i_win_shift;
				stride_q    <= i_stride;
				windows_q   <= i_windows;
				rd_win      <= '0;
				rd_atom     <= '0;
				rd_word     <= '0;
				lane_atom   <= '0;
				done_cnt    <= '0;
				res_pend    <= 1'b0;
			end else begin
				if (job_end) o_ready <= 1'b1;  // Held until the next accepted start
				if (i_rd_we) begin
					rd_word <= rd_word + 1'b1;  // Wraps per burst
					if (&rd_word) begin
						if (rd_atom == last_atom) begin
							rd_atom <= '0;
							rd_win  <= rd_win + count_t'(1);
						end else begin
							rd_atom <= rd_atom + count_t'(1);
						end
					end
				end
				if (win_end) res_pend <= 1'b1;
				else if (i_wr_busy) res_pend <= 1'b0;  // Writer has taken it
				if (i_atom_valid) lane_atom <= o_atom_last ? '0 : lane_atom + count_t'(1);
				if (i_wr_done) done_cnt <= done_cnt + count_t'(1);
			end
		end
	end

	// Read address walk, windows are re-read from their own base
	always_ff @(posedge clk) begin
		if (accept) begin
			base_addr <= i_data_addr;
			o_rd_addr <= i_data_addr;
		end else if (win_end) begin
			base_addr <= base_addr + win_step;
			o_rd_addr <= base_addr + win_step;  // Jump to the next window start
		end else if (i_rd_we) begin
			o_rd_addr <= o_rd_addr + addr_t'(1);
		end
	end

endmodule

//--- source/pool_engine.sv
`timescale 1ns/10ps

module pool_engine (
	input  logic               clk,
	input  logic               rst,
	// Job command
	input  logic               i_start,
	input  pool_pkg::pool_op_t i_op,
	input  logic [1:0]         i_win_shift,
	input  pool_pkg::count_t   i_stride,
	input  pool_pkg::count_t   i_windows,
	input  pool_pkg::addr_t    i_data_addr,
	input  pool_pkg::addr_t    i_result_addr,
	output logic               o_ready,
	// DMA read port
	output logic               o_rd_en,
	output pool_pkg::addr_t    o_rd_addr,
	input  logic               i_rd_we,
	input  pool_pkg::word_t    i_rd_data,
	// DMA write port
	output logic               o_wr_en,
	input  logic               i_wr_re,
	output logic               o_wr_valid,
	output pool_pkg::word_t    o_wr_data,
	output pool_pkg::addr_t    o_wr_addr
);
	import pool_pkg::*;

	logic       atom_valid;
	atom_t      atom_data;    // Deserialized burst
	logic       atom_first;
	logic       atom_last;
	pool_op_t   op;           // Latched job op
	logic [1:0] win_shift;
	logic       win_valid;
	atom_t      win_result;   // Reduced window, one word per lane
	logic       wr_busy;
	logic       wr_done;

	pool_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.i_start      (i_start),
		.i_op         (i_op),
		.i_win_shift  (i_win_shift),
		.i_stride     (i_stride),
		.i_windows    (i_windows),
		.i_data_addr  (i_data_addr),
		.i_rd_we      (i_rd_we),
		.i_atom_valid (atom_valid),
		.i_wr_busy    (wr_busy),
		.i_wr_done    (wr_done),
		.o_ready      (o_ready),
		.o_rd_en      (o_rd_en),
		.o_rd_addr    (o_rd_addr),
		.o_op         (op),
		.o_win_shift  (win_shift),
		.o_atom_first (atom_first),
		.o_atom_last  (atom_last)
	);

	atom_deserializer u_deser (
		.clk          (clk),
		.rst          (rst),
		.i_rd_we      (i_rd_we),
		.i_rd_data    (i_rd_data),
		.o_atom_valid (atom_valid),
		.o_atom_data  (atom_data)
	);

	pool_lanes u_lanes (
		.clk          (clk),
		.rst          (rst),
		.i_op         (op),
		.i_win_shift  (win_shift),
		.i_atom_valid (atom_valid),
		.i_atom_data  (atom_data),
		.i_atom_first (atom_first),
		.i_atom_last  (atom_last),
		.o_win_valid  (win_valid),
		.o_win_result (win_result)
	);

	// Address load on the raw strobe, jobs are only issued between jobs
	result_writer u_writer (
		.clk           (clk),
		.rst           (rst),
		.i_result_addr (i_result_addr),
		.i_start       (i_start),
		.i_win_valid   (win_valid),
		.i_win_result  (win_result),
		.i_wr_re       (i_wr_re),
		.o_wr_en       (o_wr_en),
		.o_wr_valid    (o_wr_valid),
		.o_wr_data     (o_wr_data),
		.o_wr_addr     (o_wr_addr),
		.o_busy        (wr_busy),
		.o_done        (wr_done)
	);

endmodule

//--- source/pool_lanes.sv
`timescale 1ns/10ps

module pool_lanes (
	input  logic               clk,
	input  logic               rst,
	input  pool_pkg::pool_op_t i_op,
	input  logic [1:0]         i_win_shift,
	input  logic               i_atom_valid,
	input  pool_pkg::atom_t    i_atom_data,
	input  logic               i_atom_first,
	input  logic               i_atom_last,
	output logic               o_win_valid,
	output pool_pkg::atom_t    o_win_result
);
	import pool_pkg::*;

	atom_t acc_q;    // Running max or sum per lane
	atom_t acc_nxt;
	atom_t res_nxt;  // Value to publish on the last atom

	for (genvar l = 0; l < BURST_LEN; l++) begin : g_lane
		word_t in_w;
		word_t acc_w;
		word_t sum_w;
		word_t max_w;
		word_t nxt_w;

		assign in_w  = i_atom_data[l*WORD_W +: WORD_W];
		assign acc_w = acc_q[l*WORD_W +: WORD_W];
		assign sum_w = acc_w + in_w;  // Wraps at 16 bits
		assign max_w = ($signed(in_w) > $signed(acc_w)) ? in_w : acc_w;
		assign nxt_w = i_atom_first ? in_w : ((i_op == OP_AVG) ? sum_w : max_w);

		assign acc_nxt[l*WORD_W +: WORD_W] = nxt_w;
		// Power-of-two window, so the mean is an arithmetic shift
		assign res_nxt[l*WORD_W +: WORD_W] = (i_op == OP_AVG) ?
			word_t'($signed(nxt_w) >>> i_win_shift) : nxt_w;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_win_valid <= 1'b0;
		end else begin
			o_win_valid <= i_atom_valid && i_atom_last;  // One cycle after the last atom
		end
	end

	always_ff @(posedge clk) begin
		if (i_atom_valid) begin
			acc_q <= acc_nxt;
			if (i_atom_last) o_win_result <= res_nxt;
		end
	end

endmodule

//--- source/pool_pkg.sv
package pool_pkg;

	// Atom geometry
	localparam int BURST_LEN   = 8;                  // Lanes per atom, words per burst
	localparam int BURST_SHIFT = $clog2(BURST_LEN);  // log2 of the burst length
	localparam int WORD_W      = 16;                 // Channel value width
	localparam int ADDR_W      = 30;                 // DMA word address width
	localparam int COUNT_W     = 8;                  // Window, atom and stride counts

	typedef logic [WORD_W-1:0] word_t;               // One channel value, signed for max
	typedef logic [ADDR_W-1:0] addr_t;               // Word address
	typedef logic [BURST_LEN*WORD_W-1:0] atom_t;     // Lane 0 sits in the low bits
	typedef logic [COUNT_W-1:0] count_t;

	// Operation codes follow the engine command encoding
	typedef enum logic [2:0] {
		OP_MAX = 3'd2,  // Max pooling
		OP_AVG = 3'd3   // Average pooling
	} pool_op_t;

	// Job sequencing
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,  // Reading windows, writeback overlaps
		ST_DONE
	} ctrl_state_t;

endpackage

//--- source/result_writer.sv
`timescale 1ns/10ps

module result_writer (
	input  logic            clk,
	input  logic            rst,
	input  pool_pkg::addr_t i_result_addr,
	input  logic            i_start,
	input  logic            i_win_valid,
	input  pool_pkg::atom_t i_win_result,
	input  logic            i_wr_re,
	output logic            o_wr_en,
	output logic            o_wr_valid,
	output pool_pkg::word_t o_wr_data,
	output pool_pkg::addr_t o_wr_addr,
	output logic            o_busy,
	output logic            o_done
);
	import pool_pkg::*;

	atom_t                res_q;    // Window result being drained
	logic [BURST_SHIFT:0] wr_cnt;   // Words taken, BURST_LEN when empty
	logic                 take;     // Memory accepts one word

	// Top bit set means all lanes are out
	assign o_wr_en = !wr_cnt[BURST_SHIFT];
	assign take    = i_wr_re && o_wr_en;
	assign o_busy  = o_wr_en || o_wr_valid;  // Covers the final valid word

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_cnt     <= {1'b1, {BURST_SHIFT{1'b0}}};  // Idle, nothing to write
			o_wr_valid <= 1'b0;
			o_done     <= 1'b0;
		end else begin
			o_wr_valid <= take;
			o_done     <= take && (&wr_cnt[BURST_SHIFT-1:0]);  // Eighth word
			if (i_win_valid) begin
				wr_cnt <= '0;
			end else if (take) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_win_valid) res_q <= i_win_result;
		if (take) begin
			o_wr_data <= res_q[wr_cnt[BURST_SHIFT-1:0]*WORD_W +: WORD_W];  // Lane k on k-th take
		end
	end

	// One result address per word, continuing across windows
	always_ff @(posedge clk) begin
		if (i_start) begin
			o_wr_addr <= i_result_addr;
		end else if (o_wr_valid) begin
			o_wr_addr <= o_wr_addr + addr_t'(1);
		end
	end

endmodule

//--- test/tb_dma_model.sv
`timescale 1ns/10ps

module tb_dma_model (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_slow_wr,   // Fixed long gap between write takes
	input  logic            i_rd_en,
	input  pool_pkg::addr_t i_rd_addr,
	output logic            o_rd_we,
	output pool_pkg::word_t o_rd_data,
	input  logic            i_wr_en,
	output logic            o_wr_re,
	input  logic            i_wr_valid,
	input  pool_pkg::word_t i_wr_data,
	input  pool_pkg::addr_t i_wr_addr
);
	import pool_pkg::*;

	word_t mem [0:1023];  // Word addresses wrap at 1K
	int    seed;
	int    rd_gap;        // Idle cycles left before the next read strobe
	int    wr_gap;        // Idle cycles left before the next write take

	function automatic int rand_gap();
		return int'({$random(seed)} % 4);  // 0 to 3 cycles
	endfunction

	initial begin
		seed      = 33703;
		rd_gap    = 0;
		wr_gap    = 0;
		o_rd_we   = 1'b0;
		o_rd_data = '0;
		o_wr_re   = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = word_t'($random(seed));  // Random source data
		end
	end

	// Responses change shortly after the edge and are taken on the next one
	always @(posedge clk) begin
		#2;
		o_rd_we = 1'b0;
		o_wr_re = 1'b0;
		if (!rst) begin
			if (rd_gap > 0) begin
				rd_gap--;
			end else if (i_rd_en) begin
				o_rd_we   = 1'b1;
				o_rd_data = mem[i_rd_addr[9:0]];  // Data rides with the strobe
				rd_gap    = rand_gap();
			end
			if (wr_gap > 0) begin
				wr_gap--;
			end else if (i_wr_en) begin
				o_wr_re = 1'b1;
				wr_gap  = i_slow_wr ? 12 : rand_gap();
			end
			if (i_wr_valid) mem[i_wr_addr[9:0]] = i_wr_data;  // Store the result word
		end
	end

endmodule

//--- test/tb_pool_engine.sv
`timescale 1ns/10ps

module tb_pool_engine;
	import pool_pkg::*;

	logic       clk;
	logic       rst;
	logic       start;
	pool_op_t   op;
	logic [1:0] win_shift;
	count_t     stride;
	count_t     windows;
	addr_t      data_addr;
	addr_t      result_addr;
	logic       ready;
	logic       rd_en;
	addr_t      rd_addr;
	logic       rd_we;
	word_t      rd_data;
	logic       wr_en;
	logic       wr_re;
	logic       wr_valid;
	word_t      wr_data;
	addr_t      wr_addr;
	logic       slow_wr;      // Long write gaps in the memory model

	pool_op_t   job_op;       // Active job as seen by the reference model
	int         job_shift;
	int         job_stride;
	int         job_data;
	int         job_result;
	int         rd_idx;       // Read strobes in this job
	int         wr_idx;       // Result words in this job
	int         rd_err;       // Bad read addresses over the whole run
	int         errors;
	int         checks;
	int         tests;
	int         test_err0;    // Error count when the current test began

	pool_engine u_dut (
		.clk           (clk),
		.rst           (rst),
		.i_start       (start),
		.i_op          (op),
		.i_win_shift   (win_shift),
		.i_stride      (stride),
		.i_windows     (windows),
		.i_data_addr   (data_addr),
		.i_result_addr (result_addr),
		.o_ready       (ready),
		.o_rd_en       (rd_en),
		.o_rd_addr     (rd_addr),
		.i_rd_we       (rd_we),
		.i_rd_data     (rd_data),
		.o_wr_en       (wr_en),
		.i_wr_re       (wr_re),
		.o_wr_valid    (wr_valid),
		.o_wr_data     (wr_data),
		.o_wr_addr     (wr_addr)
	);

	tb_dma_model u_mem (
		.clk        (clk),
		.rst        (rst),
		.i_slow_wr  (slow_wr),
		.i_rd_en    (rd_en),
		.i_rd_addr  (rd_addr),
		.o_rd_we    (rd_we),
		.o_rd_data  (rd_data),
		.i_wr_en    (wr_en),
		.o_wr_re    (wr_re),
		.i_wr_valid (wr_valid),
		.i_wr_data  (wr_data),
		.i_wr_addr  (wr_addr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == test_err0) ? "ok" : "failed");
		test_err0 = errors;
	endtask

	// Lane k of window n from the source words in memory
	function automatic word_t expect_word(input int n, input int k);
		int                       sum;
		int                       best;
		int                       v;
		int                       idx;
		logic signed [WORD_W-1:0] wrapped;
		sum  = 0;
		best = 0;
		for (int i = 0; i < (1 << job_shift); i++) begin
			idx = job_data + (n * job_stride + i) * 8 + k;  // Word k of atom n*stride+i
			v   = int'($signed(u_mem.mem[idx[9:0]]));
			sum += v;
			if (i == 0 || v > best) best = v;
		end
		wrapped = sum[WORD_W-1:0];  // 16-bit wrapped lane sum
		if (job_op == OP_AVG) return word_t'(wrapped >>> job_shift);
		return word_t'(best);
	endfunction

	// Bus checks at the falling edge where everything is settled
	always @(negedge clk) begin : bus_monitor
		int wpw;
		int exp_a;
		int e0;
		if (!rst) begin
			wpw = 8 << job_shift;  // Words per window
			if (rd_we) begin
				exp_a = job_data + (rd_idx / wpw) * job_stride * 8 + rd_idx % wpw;
				e0    = errors;
				check_val("o_rd_addr", 32'(rd_addr), exp_a);
				if (errors != e0) rd_err++;
				rd_idx++;
			end
			if (wr_valid) begin
				check_val("o_wr_addr", 32'(wr_addr), job_result + wr_idx);
				check_val("o_wr_data", 32'(wr_data), 32'(expect_word(wr_idx / 8, wr_idx % 8)));
				wr_idx++;
			end
		end
	end

	task automatic run_job(input pool_op_t j_op, input int shift, input int strd,
		input int wins, input int d_addr, input int r_addr);
		int   wait_cyc;
		logic prev_valid;
		repeat (2) @(posedge clk);
		#2;
		job_op      = j_op;
		job_shift   = shift;
		job_stride  = strd;
		job_data    = d_addr;
		job_result  = r_addr;
		rd_idx      = 0;
		wr_idx      = 0;
		op          = j_op;
		win_shift   = 2'(shift);
		stride      = count_t'(strd);
		windows     = count_t'(wins);
		data_addr   = addr_t'(d_addr);
		result_addr = addr_t'(r_addr);
		start       = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		@(negedge clk);
		check_val("o_ready", 32'(ready), 0);  // Cleared by the accepted start
		wait_cyc   = 0;
		prev_valid = 1'b0;
		while (!ready && wait_cyc < 4000) begin
			prev_valid = wr_valid;
			@(negedge clk);
			wait_cyc++;
		end
		if (!ready) begin
			errors++;
			$display("Timed out after %0d cycles waiting for o_ready", wait_cyc);
		end else begin
			check_val("o_wr_valid before o_ready", 32'(prev_valid), 1);  // Last word one cycle earlier
			check_val("o_wr_valid pulses", wr_idx, wins * 8);
			check_val("i_rd_we strobes", rd_idx, wins * (8 << shift));
		end
	endtask

	initial begin
		rst         = 1'b1;
		start       = 1'b0;
		op          = OP_MAX;
		win_shift   = '0;
		stride      = '0;
		windows     = '0;
		data_addr   = '0;
		result_addr = '0;
		slow_wr     = 1'b0;
		job_op      = OP_MAX;
		job_shift   = 0;
		job_stride  = 0;
		job_data    = 0;
		job_result  = 0;
		rd_idx      = 0;
		wr_idx      = 0;
		rd_err      = 0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		test_err0   = 0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// Quiet outputs after reset and after a start with an unsupported op
		@(negedge clk);
		check_val("o_ready", 32'(ready), 0);
		check_val("o_rd_en", 32'(rd_en), 0);
		check_val("o_wr_en", 32'(wr_en), 0);
		check_val("o_wr_valid", 32'(wr_valid), 0);
		@(posedge clk);
		#2;
		op    = pool_op_t'(3'd1);
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		repeat (20) begin
			@(negedge clk);
			check_val("o_ready", 32'(ready), 0);
			check_val("o_rd_en", 32'(rd_en), 0);
		end
		end_test("reset and invalid op");

		run_job(OP_MAX, 1, 1, 4, 0, 512);  // Overlapping windows re-read their shared atom
		end_test("max pooling");

		run_job(OP_AVG, 2, 2, 3, 64, 600);
		end_test("average pooling");

		slow_wr = 1'b1;  // Writer drains slowly and reads back off
		run_job(OP_MAX, 2, 1, 3, 200, 700);
		slow_wr = 1'b0;
		end_test("slow writeback");

		@(negedge clk);
		check_val("o_ready", 32'(ready), 1);  // Still held from the last job
		run_job(OP_AVG, 1, 3, 2, 300, 800);
		end_test("ready and second job");

		tests++;
		$display("test %0d read address order: %s", tests, (rd_err == 0) ? "ok" : "failed");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
